/* Makefile */
SIM      = verilator
TOP      = tb_mem_subsystem
FILELIST = mem_subsystem.f
FLAGS    = --binary --timing --assert -j 0
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* hw/bank_fsm.sv */
module bank_fsm
	import mem_pkg::*;
(
	input  logic                clk,
	input  logic                rst_n,
	input  logic                need_to_work,
	input  logic                write,
	input  logic [OFFSET_W-1:0] offset,
	input  logic [DATA_W-1:0]   wdata,
	output logic                bank_done,
	output logic [DATA_W-1:0]   bank_rdata
);

	logic [STATE_W-1:0] state;
	logic               start;
	logic               expired;
	logic               rd_en;
	logic               we;

	////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////

	assign start     = (state == ST_IDLE) && need_to_work;
	assign rd_en     = (state == ST_ACCESS) && expired;
	assign bank_done = (state == ST_DONE);

	// Write lands at the edge closing the done cycle
	assign we = bank_done && write;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:   if (need_to_work) state <= ST_ACCESS;
				ST_ACCESS: if (expired) state <= ST_DONE;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	wait_timer timer_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.expired (expired)
	);

	sram_bank sram_inst (
		.clk   (clk),
		.we    (we),
		.rd_en (rd_en),
		.index (offset[INDEX_W-1:0]),
		.wdata (wdata),
		.rdata (bank_rdata)
	);

	a_done_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		bank_done |=> !bank_done
	) else $error("bank_done held longer than one cycle");

endmodule

/* hw/mem_pkg.sv */
package mem_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	localparam int DATA_W     = 16;
	localparam int ADDR_W     = 16;
	localparam int OFFSET_W   = 15;

	// Only the low offset bits reach the array
	localparam int BANK_DEPTH = 256;
	localparam int INDEX_W    = $clog2(BANK_DEPTH);

	////////////////////////////////////////
	// Access timing
	////////////////////////////////////////

	localparam int WAIT_CYCLES = 3;
	localparam int TIMER_W     = $clog2(WAIT_CYCLES + 1);

	// Bank state encoding
	localparam int         STATE_W   = 2;
	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_ACCESS = 2'd1;
	localparam logic [1:0] ST_DONE   = 2'd2;

	////////////////////////////////////////
	// Serial receiver window
	////////////////////////////////////////

	localparam logic [ADDR_W-1:0] UART_DATA_ADDR = 16'hBF00;
	localparam logic [ADDR_W-1:0] UART_STAT_ADDR = 16'hBF01;

	// Address word seen raw or as bank select and offset
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		struct packed {
			logic                bank_hi;
			logic [OFFSET_W-1:0] offset;
		} f;
	} mem_addr_u;

endpackage

/* hw/mem_subsystem.sv */
module mem_subsystem
	import mem_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mem_rd,
	input  logic              mem_wr,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] wr_data,
	input  logic              rx_valid,
	input  logic [7:0]        rx_byte,
	output logic              work_done,
	output logic [DATA_W-1:0] feedback
);

	logic              ram1_need_to_work;
	logic              ram2_need_to_work;
	logic              ram1_done;
	logic              ram2_done;
	logic [DATA_W-1:0] ram1_rdata;
	logic [DATA_W-1:0] ram2_rdata;
	logic              ready;
	logic [7:0]        rx_data;
	logic              clear_ready;

	ram_controller ram_controller_inst (
		.mem_rd            (mem_rd),
		.mem_wr            (mem_wr),
		.addr              (addr),
		.ram1_done         (ram1_done),
		.ram1_rdata        (ram1_rdata),
		.ram2_done         (ram2_done),
		.ram2_rdata        (ram2_rdata),
		.ready             (ready),
		.rx_data           (rx_data),
		.ram1_need_to_work (ram1_need_to_work),
		.ram2_need_to_work (ram2_need_to_work),
		.work_done         (work_done),
		.feedback          (feedback),
		.clear_ready       (clear_ready)
	);

	// Bank 1 answers addresses with bit 15 set
	bank_fsm bank1_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.need_to_work (ram1_need_to_work),
		.write        (mem_wr),
		.offset       (addr[OFFSET_W-1:0]),
		.wdata        (wr_data),
		.bank_done    (ram1_done),
		.bank_rdata   (ram1_rdata)
	);

	bank_fsm bank2_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.need_to_work (ram2_need_to_work),
		.write        (mem_wr),
		.offset       (addr[OFFSET_W-1:0]),
		.wdata        (wr_data),
		.bank_done    (ram2_done),
		.bank_rdata   (ram2_rdata)
	);

	uart_status uart_status_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_valid    (rx_valid),
		.rx_byte     (rx_byte),
		.clear_ready (clear_ready),
		.ready       (ready),
		.rx_data     (rx_data)
	);

endmodule

/* hw/ram_controller.sv */
module ram_controller
	import mem_pkg::*;
(
	input  logic              mem_rd,
	input  logic              mem_wr,
	input  logic [ADDR_W-1:0] addr,
	input  logic              ram1_done,
	input  logic [DATA_W-1:0] ram1_rdata,
	input  logic              ram2_done,
	input  logic [DATA_W-1:0] ram2_rdata,
	input  logic              ready,
	input  logic [7:0]        rx_data,
	output logic              ram1_need_to_work,
	output logic              ram2_need_to_work,
	output logic              work_done,
	output logic [DATA_W-1:0] feedback,
	output logic              clear_ready
);

	mem_addr_u a;

	assign a.raw = addr;

	always_comb begin
		ram1_need_to_work = 1'b0;
		ram2_need_to_work = 1'b0;
		work_done         = 1'b0;
		feedback          = '0;
		clear_ready       = 1'b0;
		if (mem_rd || mem_wr) begin
			if (a.raw == UART_STAT_ADDR) begin
				// Transmitter always idle so bit 0 stays set
				work_done = 1'b1;
				feedback  = {14'h3FFF, ready, 1'b1};
			end else if (a.raw == UART_DATA_ADDR) begin
				work_done   = 1'b1;
				feedback    = {8'h00, rx_data};
				clear_ready = mem_rd;
			end else if (a.f.bank_hi) begin
				if (ram1_done) begin
					work_done = 1'b1;
					feedback  = ram1_rdata;
				end else begin
					ram1_need_to_work = 1'b1;
				end
			end else begin
				if (ram2_done) begin
					work_done = 1'b1;
					feedback  = ram2_rdata;
				end else begin
					ram2_need_to_work = 1'b1;
				end
			end
		end
	end

	// Requester protocol
	always_comb begin
		assert (!(mem_rd && mem_wr)) else $error("mem_rd and mem_wr both high");
	end

endmodule

/* hw/sram_bank.sv */
module sram_bank
	import mem_pkg::*;
(
	input  logic               clk,
	input  logic               we,
	input  logic               rd_en,
	input  logic [INDEX_W-1:0] index,
	input  logic [DATA_W-1:0]  wdata,
	output logic [DATA_W-1:0]  rdata
);

	logic [DATA_W-1:0] mem [BANK_DEPTH];

	// Write port
	always_ff @(posedge clk) begin
		if (we)
			mem[index] <= wdata;
	end

	// Read data lands one edge after rd_en
	always_ff @(posedge clk) begin
		if (rd_en)
			rdata <= mem[index];
	end

endmodule

/* hw/uart_status.sv */
module uart_status
	import mem_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rx_valid,
	input  logic [7:0] rx_byte,
	input  logic       clear_ready,
	output logic       ready,
	output logic [7:0] rx_data
);

	////////////////////////////////////////
	// Ready flag
	////////////////////////////////////////

	// A new byte beats a clear in the same cycle
	always_ff @(posedge clk) begin
		if (!rst_n)
			ready <= 1'b0;
		else if (rx_valid)
			ready <= 1'b1;
		else if (clear_ready)
			ready <= 1'b0;
	end

	////////////////////////////////////////
	// Byte holding register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rx_valid)
			rx_data <= rx_byte;
	end

endmodule

/* hw/wait_timer.sv */
module wait_timer
	import mem_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic expired
);

	logic [TIMER_W-1:0] count;

	// Down-counter whose expired flag sticks until the next start
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count   <= '0;
			expired <= 1'b0;
		end else if (start) begin
			count   <= TIMER_W'(WAIT_CYCLES);
			expired <= 1'b0;
		end else if (count != '0) begin
			count <= count - 1'b1;
			if (count == TIMER_W'(1))
				expired <= 1'b1;
		end
	end

	// A bank never restarts mid-wait
	a_no_restart: assert property (
		@(posedge clk) disable iff (!rst_n)
		start |-> (count == '0)
	) else $error("wait_timer restarted while counting");

endmodule

/* mem_subsystem.f */
hw/mem_pkg.sv
hw/wait_timer.sv
hw/sram_bank.sv
hw/bank_fsm.sv
hw/uart_status.sv
hw/ram_controller.sv
hw/mem_subsystem.sv
tb/mem_checker.sv
tb/tb_mem_subsystem.sv

/* tb/mem_checker.sv */
module mem_checker
	import mem_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mem_rd,
	input  logic              mem_wr,
	input  logic [ADDR_W-1:0] addr,
	input  logic              work_done,
	input  logic [DATA_W-1:0] feedback,
	input  logic [DATA_W-1:0] exp_data,
	output int                value_errors,
	output int                timing_errors,
	output int                other_errors
);

	timeunit 1ns;
	timeprecision 1ps;

	// Name of the table entry in flight
	string test_name = "";

	int   wait_edges;
	int   exp_edges;
	logic reserved;

	assign reserved = (addr == UART_DATA_ADDR) || (addr == UART_STAT_ADDR);

	////////////////////////////////////////
	// Per-edge comparison
	////////////////////////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			wait_edges    = 0;
			value_errors  = 0;
			timing_errors = 0;
			other_errors  = 0;
		end else if (mem_rd || mem_wr) begin
			if (work_done === 1'b1) begin
				// Reserved addresses answer at once and banks after the wait
				exp_edges = reserved ? 0 : WAIT_CYCLES + 2;
				if (wait_edges != exp_edges) begin
					$display("Fail %s: expected %0d edges before work_done, actual %0d",
						test_name, exp_edges, wait_edges);
					timing_errors++;
				end
				if (mem_rd && (feedback !== exp_data)) begin
					$display("Fail %s: expected %h, actual %h",
						test_name, exp_data, feedback);
					value_errors++;
				end
				wait_edges = 0;
			end else begin
				wait_edges++;
			end
		end else begin
			if (work_done !== 1'b0) begin
				$display("work_done was not low while no request was pending (%s)",
					test_name);
				other_errors++;
			end
			wait_edges = 0;
		end
	end

endmodule

/* tb/tb_mem_subsystem.sv */
module tb_mem_subsystem
	import mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int         N_TESTS     = 17;
	localparam int         IDLE_CYCLES = 10;
	localparam int         TIMEOUT     = N_TESTS * (WAIT_CYCLES + 4) + 50;
	localparam logic [1:0] OP_READ     = 2'd0;
	localparam logic [1:0] OP_WRITE    = 2'd1;
	localparam logic [1:0] OP_RX       = 2'd2;
	localparam logic [1:0] OP_IDLE     = 2'd3;

	logic              clk;
	logic              rst_n;
	logic              mem_rd;
	logic              mem_wr;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wr_data;
	logic              rx_valid;
	logic [7:0]        rx_byte;
	logic              work_done;
	logic [DATA_W-1:0] feedback;
	logic [DATA_W-1:0] exp_data;
	int                value_errors;
	int                timing_errors;
	int                other_errors;
	int                cycle_count;

	// Stimulus table
	logic [1:0]        op_tbl    [N_TESTS];
	logic [ADDR_W-1:0] addr_tbl  [N_TESTS];
	logic [DATA_W-1:0] wdata_tbl [N_TESTS];
	logic [DATA_W-1:0] exp_tbl   [N_TESTS];
	string             name_tbl  [N_TESTS];
	int                n_built;

	// Expected bank contents by bank select and array index
	logic [DATA_W-1:0] model [2][BANK_DEPTH];
	logic [31:0]       rnd_state;
	logic [7:0]        rx_last;

	mem_subsystem mem_subsystem_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.addr      (addr),
		.wr_data   (wr_data),
		.rx_valid  (rx_valid),
		.rx_byte   (rx_byte),
		.work_done (work_done),
		.feedback  (feedback)
	);

	mem_checker checker_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.mem_rd        (mem_rd),
		.mem_wr        (mem_wr),
		.addr          (addr),
		.work_done     (work_done),
		.feedback      (feedback),
		.exp_data      (exp_data),
		.value_errors  (value_errors),
		.timing_errors (timing_errors),
		.other_errors  (other_errors)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////////////////////////
	// Table building
	////////////////////////////////////////

	task automatic add_entry(input logic [1:0] op, input logic [ADDR_W-1:0] a,
		input logic [DATA_W-1:0] exp, input string name);
		logic bank_addr;
		bank_addr = (a != UART_DATA_ADDR) && (a != UART_STAT_ADDR);
		rnd_state = xorshift(rnd_state);
		if (n_built < N_TESTS) begin
			op_tbl[n_built]    = op;
			addr_tbl[n_built]  = a;
			wdata_tbl[n_built] = rnd_state[DATA_W-1:0];
			exp_tbl[n_built]   = exp;
			name_tbl[n_built]  = name;
			// Only bank writes update the model
			if (op == OP_WRITE && bank_addr)
				model[a[ADDR_W-1]][a[INDEX_W-1:0]] = rnd_state[DATA_W-1:0];
			if (op == OP_READ && bank_addr)
				exp_tbl[n_built] = model[a[ADDR_W-1]][a[INDEX_W-1:0]];
			if (op == OP_RX)
				rx_last = rnd_state[7:0];
		end
		n_built++;
	endtask

	// Bank 1 words at index 0 and 1 share their index with the serial window
	task automatic build_table();
		add_entry(OP_IDLE,  16'h0000, 16'h0000, "idle_after_reset");
		add_entry(OP_WRITE, 16'h8001, 16'h0000, "wr_bank1");
		add_entry(OP_WRITE, 16'h0001, 16'h0000, "wr_bank2");
		add_entry(OP_READ,  16'h8001, 16'h0000, "rd_bank1");
		add_entry(OP_READ,  16'h0001, 16'h0000, "rd_bank2");
		add_entry(OP_WRITE, 16'h8000, 16'h0000, "wr_bank1_b");
		add_entry(OP_READ,  16'h8000, 16'h0000, "rd_bank1_b");
		add_entry(OP_READ,  UART_STAT_ADDR, 16'hFFFD, "stat_empty");
		add_entry(OP_RX,    16'h0000, 16'h0000, "rx_pulse");
		add_entry(OP_READ,  UART_STAT_ADDR, 16'hFFFF, "stat_ready");
		add_entry(OP_READ,  UART_DATA_ADDR, {8'h00, rx_last}, "rx_data");
		add_entry(OP_READ,  UART_STAT_ADDR, 16'hFFFD, "stat_cleared");
		add_entry(OP_WRITE, UART_DATA_ADDR, 16'h0000, "wr_uart_data");
		add_entry(OP_WRITE, UART_STAT_ADDR, 16'h0000, "wr_uart_stat");
		add_entry(OP_READ,  16'h8001, 16'h0000, "reread_bank1");
		add_entry(OP_READ,  16'h0001, 16'h0000, "reread_bank2");
		add_entry(OP_READ,  16'h8000, 16'h0000, "reread_bank1_b");
	endtask

	// Request held until work_done is seen on an edge
	task automatic run_entry(input int i);
		@(negedge clk);
		checker_inst.test_name = name_tbl[i];
		exp_data = exp_tbl[i];
		case (op_tbl[i])
			OP_IDLE: begin
				repeat (IDLE_CYCLES) @(posedge clk);
			end
			OP_RX: begin
				rx_byte  = wdata_tbl[i][7:0];
				rx_valid = 1'b1;
				@(negedge clk);
				rx_valid = 1'b0;
			end
			default: begin
				addr    = addr_tbl[i];
				wr_data = wdata_tbl[i];
				mem_rd  = (op_tbl[i] == OP_READ);
				mem_wr  = (op_tbl[i] == OP_WRITE);
				@(posedge clk);
				while (!work_done)
					@(posedge clk);
				@(negedge clk);
				mem_rd = 1'b0;
				mem_wr = 1'b0;
			end
		endcase
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the stimulus table did not finish within %0d cycles", TIMEOUT);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		rst_n     = 1'b0;
		mem_rd    = 1'b0;
		mem_wr    = 1'b0;
		addr      = '0;
		wr_data   = '0;
		rx_valid  = 1'b0;
		rx_byte   = '0;
		exp_data  = '0;
		n_built   = 0;
		rx_last   = '0;
		rnd_state = 32'd61;
		build_table();
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < N_TESTS; i++)
			run_entry(i);
		@(negedge clk);
		if (n_built != N_TESTS)
			$display("Stimulus table holds %0d entries but %0d were added", N_TESTS, n_built);
		$display("Errors: value %0d, latency %0d, other %0d, table %0d",
			value_errors, timing_errors, other_errors, (n_built != N_TESTS) ? 1 : 0);
		if (value_errors == 0 && timing_errors == 0 && other_errors == 0 && n_built == N_TESTS)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
